// ==== cdma_status_defines.svh ====
// bank depth must be a power of two and the entry width must hold (bank field max + 1) banks
`ifndef CDMA_STATUS_DEFINES_SVH
`define CDMA_STATUS_DEFINES_SVH

//////////////////////////////////////////////////
// buffer geometry
//////////////////////////////////////////////////

// entry count, free count and write index width
`define CDMA_ENTRY_W 15

// slice count width
`define CDMA_SLICE_W 14

// configured bank field from the register file, holds banks minus one
`define CDMA_BANK_W 5

// log2 of entries per bank, 512 entries
`define CDMA_BANK_DEPTH_LOG2 9

//////////////////////////////////////////////////
// timing
//////////////////////////////////////////////////

// producer update to sc forward, in cycles
`define CDMA_STATUS_LATENCY 9

`endif

// ==== cdma_status_pkg.sv ====
// types only; widths come from the defines header, which must be compiled with this package
`default_nettype none

`include "cdma_status_defines.svh"

package cdma_status_pkg;

  //////////////////////////////////////////////////
  // counts and indexes
  //////////////////////////////////////////////////

  // entry count, free count, capacity or write index
  typedef logic [`CDMA_ENTRY_W-1:0] entries_t;

  // slice count
  typedef logic [`CDMA_SLICE_W-1:0] slices_t;

  // bank field as programmed, real bank count is this plus one
  typedef logic [`CDMA_BANK_W-1:0] bank_t;

  //////////////////////////////////////////////////
  // producer state and interrupts
  //////////////////////////////////////////////////

  // encoding shared with the fetch engines
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_PEND = 2'd1,
    FETCH_BUSY = 2'd2,
    FETCH_DONE = 2'd3
  } fetch_state_e;

  // bit 0 to consumer 0, bit 1 to consumer 1
  typedef logic [1:0] intr_t;

endpackage

`default_nettype wire

// ==== cdma_updt_delay.sv ====
// fixed latency shift with LATENCY of at least one; the payload is only valid with its strobe
`timescale 1ns/1ps
`default_nettype none

`include "cdma_status_defines.svh"

module cdma_updt_delay
  import cdma_status_pkg::*;
#(
  parameter int LATENCY = `CDMA_STATUS_LATENCY
) (
  input  wire      nvdla_core_clk,
  input  wire      rst_n,
  input  wire      in_updt,
  input  entries_t in_entries,
  input  slices_t  in_slices,
  output logic     out_updt,
  output entries_t out_entries,
  output slices_t  out_slices
);

  logic [LATENCY-1:0] updt_q;
  entries_t           entries_q [LATENCY];
  slices_t            slices_q [LATENCY];

  // strobe chain shifts every cycle
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      updt_q <= '0;
    end else begin
      updt_q[0] <= in_updt;
      for (int i = 1; i < LATENCY; i++) begin
        updt_q[i] <= updt_q[i-1];
      end
    end
  end

  // data stages move only behind a strobe and idle stages hold
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < LATENCY; i++) begin
        entries_q[i] <= '0;
        slices_q[i]  <= '0;
      end
    end else begin
      if (in_updt) begin
        entries_q[0] <= in_entries;
        slices_q[0]  <= in_slices;
      end
      for (int i = 1; i < LATENCY; i++) begin
        if (updt_q[i-1]) begin
          entries_q[i] <= entries_q[i-1];
          slices_q[i]  <= slices_q[i-1];
        end
      end
    end
  end

  assign out_updt    = updt_q[LATENCY-1];
  assign out_entries = entries_q[LATENCY-1];
  assign out_slices  = slices_q[LATENCY-1];

endmodule

`default_nettype wire

// ==== cdma_wr_idx.sv ====
// a single add must be smaller than capacity, the index wraps at most once per add
`timescale 1ns/1ps
`default_nettype none

`include "cdma_status_defines.svh"

module cdma_wr_idx
  import cdma_status_pkg::*;
(
  input  wire      nvdla_core_clk,
  input  wire      rst_n,
  input  wire      add_updt,
  input  entries_t add_entries,
  input  wire      clear,
  input  entries_t capacity,
  output entries_t wr_idx
);

  logic [`CDMA_ENTRY_W:0] idx_inc;
  logic                   idx_overflow;
  entries_t               idx_wrap;
  entries_t               wr_idx_w;

  //////////////////////////////////////////////////
  // advance and wrap
  //////////////////////////////////////////////////

  // one bit wider so the compare sees sums past the entry range
  assign idx_inc      = {1'b0, wr_idx} + {1'b0, add_entries};
  assign idx_overflow = (idx_inc >= {1'b0, capacity});
  // modular subtract, the dropped top bit cancels out
  assign idx_wrap     = idx_inc[`CDMA_ENTRY_W-1:0] - capacity;

  assign wr_idx_w = clear        ? '0 :
                    idx_overflow ? idx_wrap :
                    idx_inc[`CDMA_ENTRY_W-1:0];

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx <= '0;
    end else if (add_updt || clear) begin
      wr_idx <= wr_idx_w;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // after any write the index points inside the buffer
  a_idx_in_capacity: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    (add_updt && !clear) |=> wr_idx < $past(capacity));

endmodule

`default_nettype wire

// ==== cdma_buf_occupancy.sv ====
// sc releases must never exceed what was written; clear wins over add and release in one cycle
`timescale 1ns/1ps
`default_nettype none

`include "cdma_status_defines.svh"

module cdma_buf_occupancy
  import cdma_status_pkg::*;
(
  input  wire      nvdla_core_clk,
  input  wire      rst_n,
  input  wire      add_updt,
  input  entries_t add_entries,
  input  slices_t  add_slices,
  input  wire      sc_dat_updt,
  input  entries_t sc_dat_entries,
  input  slices_t  sc_dat_slices,
  input  wire      clear,
  input  entries_t capacity,
  output slices_t  valid_slices,
  output entries_t free_entries
);

  logic     update_all;
  entries_t entries_add;
  entries_t entries_sub;
  slices_t  slices_add;
  slices_t  slices_sub;
  entries_t valid_entries;
  entries_t valid_entries_w;
  slices_t  valid_slices_w;
  logic     entries_carry;
  logic     slices_carry;

  //////////////////////////////////////////////////
  // next counts
  //////////////////////////////////////////////////

  assign update_all  = add_updt | sc_dat_updt | clear;

  assign entries_add = add_updt ? add_entries : '0;
  assign slices_add  = add_updt ? add_slices : '0;
  assign entries_sub = sc_dat_updt ? sc_dat_entries : '0;
  assign slices_sub  = sc_dat_updt ? sc_dat_slices : '0;

  // extra top bit catches wrap in either direction
  assign {entries_carry, valid_entries_w} = clear ? '0 :
    {1'b0, valid_entries} + {1'b0, entries_add} - {1'b0, entries_sub};
  assign {slices_carry, valid_slices_w} = clear ? '0 :
    {1'b0, valid_slices} + {1'b0, slices_add} - {1'b0, slices_sub};

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_entries <= '0;
      valid_slices  <= '0;
      free_entries  <= '0;
    end else begin
      if (update_all) begin
        valid_entries <= valid_entries_w;
        valid_slices  <= valid_slices_w;
      end
      // free space tracks the next count, so it lands with the counters
      free_entries <= capacity - valid_entries_w;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_no_count_wrap: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    update_all |-> !(entries_carry | slices_carry));

  // producers only write into free space
  a_entries_in_capacity: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    add_updt |=> valid_entries <= $past(capacity));

endmodule

`default_nettype wire

// ==== cdma_status_ctrl.sv ====
// producers must not strobe together; capacity is zero until op_en has been seen once after reset
`timescale 1ns/1ps
`default_nettype none

`include "cdma_status_defines.svh"

module cdma_status_ctrl
  import cdma_status_pkg::*;
(
  input  wire          nvdla_core_clk,
  input  wire          rst_n,
  input  wire          op_en,
  input  wire          consumer,
  input  bank_t        data_bank,
  input  fetch_state_e dc_state,
  input  fetch_state_e img_state,
  input  fetch_state_e wt_state,
  input  wire          dc_dat_updt,
  input  wire          img_dat_updt,
  input  entries_t     dc_dat_entries,
  input  entries_t     img_dat_entries,
  input  slices_t      dc_dat_slices,
  input  slices_t      img_dat_slices,
  input  wire          sc_dat_pending_req,
  output logic         add_updt,
  output entries_t     add_entries,
  output slices_t      add_slices,
  output entries_t     capacity,
  output logic         clear,
  output logic         pending_ack,
  output logic         fsm_switch,
  output intr_t        wt_done_intr,
  output intr_t        dat_done_intr
);

  localparam int REAL_BANK_W = `CDMA_BANK_W + 1;

  logic                   wt_done;
  logic                   dat_done;
  logic                   any_pend;
  logic                   wt_done_d1;
  logic                   dat_done_d1;
  logic                   fsm_switch_w;
  logic                   pending_req;
  logic [REAL_BANK_W-1:0] real_bank;
  logic [REAL_BANK_W-1:0] real_bank_w;

  //////////////////////////////////////////////////
  // state decode
  //////////////////////////////////////////////////

  assign wt_done  = (wt_state == FETCH_DONE);
  // data side is done when whichever producer runs the layer is done
  assign dat_done = (dc_state == FETCH_DONE) | (img_state == FETCH_DONE);
  assign any_pend = (dc_state == FETCH_PEND) | (img_state == FETCH_PEND);

  // single pulse, held off by its own registered copy
  assign fsm_switch_w = op_en & ~fsm_switch & wt_done & dat_done;

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      fsm_switch    <= 1'b0;
      wt_done_d1    <= 1'b0;
      dat_done_d1   <= 1'b0;
      wt_done_intr  <= '0;
      dat_done_intr <= '0;
    end else begin
      fsm_switch    <= fsm_switch_w;
      wt_done_d1    <= op_en & wt_done;
      dat_done_d1   <= op_en & dat_done;
      // rising edge of done, steered to the selected consumer
      wt_done_intr  <= {op_en & consumer & ~wt_done_d1 & wt_done,
                        op_en & ~consumer & ~wt_done_d1 & wt_done};
      dat_done_intr <= {op_en & consumer & ~dat_done_d1 & dat_done,
                        op_en & ~consumer & ~dat_done_d1 & dat_done};
    end
  end

  //////////////////////////////////////////////////
  // update merge
  //////////////////////////////////////////////////

  assign add_updt    = dc_dat_updt | img_dat_updt;
  // and-or mux, only one producer strobes at a time
  assign add_entries = ({`CDMA_ENTRY_W{dc_dat_updt}} & dc_dat_entries) |
                       ({`CDMA_ENTRY_W{img_dat_updt}} & img_dat_entries);
  assign add_slices  = ({`CDMA_SLICE_W{dc_dat_updt}} & dc_dat_slices) |
                       ({`CDMA_SLICE_W{img_dat_updt}} & img_dat_slices);

  //////////////////////////////////////////////////
  // bank capacity and pending handshake
  //////////////////////////////////////////////////

  assign real_bank_w = {1'b0, data_bank} + 1'b1;
  // capacity is real banks times bank depth, a plain shift
  assign capacity    = {real_bank, {`CDMA_BANK_DEPTH_LOG2{1'b0}}};

  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      real_bank   <= '0;
      pending_ack <= 1'b0;
      pending_req <= 1'b0;
    end else begin
      // bank count only follows the register while a layer is enabled
      if (op_en && (real_bank_w != real_bank)) begin
        real_bank <= real_bank_w;
      end
      pending_ack <= op_en & any_pend;
      pending_req <= sc_dat_pending_req;
    end
  end

  // both sides agree, flush the buffer status
  assign clear = pending_ack & pending_req;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_no_done_without_op_en: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    !op_en |-> !(wt_done | dat_done));

  a_one_producer_strobe: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    !(dc_dat_updt & img_dat_updt));

  // producers are parked in pend while the sc drains, so no writes may arrive
  a_no_add_while_ack: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    pending_ack |-> !add_updt);

endmodule

`default_nettype wire

// ==== cdma_status.sv ====
// buffer status top; dc and img must not strobe in the same cycle, no back-pressure to the sc
`timescale 1ns/1ps
`default_nettype none

`include "cdma_status_defines.svh"

module cdma_status
  import cdma_status_pkg::*;
(
  input  wire          nvdla_core_clk,
  input  wire          rst_n,
  // producers
  input  wire          dc_dat_updt,
  input  entries_t     dc_dat_entries,
  input  slices_t      dc_dat_slices,
  input  fetch_state_e dc_state,
  input  wire          img_dat_updt,
  input  entries_t     img_dat_entries,
  input  slices_t      img_dat_slices,
  input  fetch_state_e img_state,
  input  fetch_state_e wt_state,
  // sc release and pending request
  input  wire          sc_dat_updt,
  input  entries_t     sc_dat_entries,
  input  slices_t      sc_dat_slices,
  input  wire          sc_dat_pending_req,
  // register file
  input  wire          op_en,
  input  bank_t        data_bank,
  input  wire          consumer,
  // forward to the sc
  output logic         sc_fwd_updt,
  output entries_t     sc_fwd_entries,
  output slices_t      sc_fwd_slices,
  // status to the fetch engines
  output slices_t      valid_slices,
  output entries_t     free_entries,
  output entries_t     wr_idx,
  output logic         pending_ack,
  output logic         fsm_switch,
  output logic         dp_done,
  output intr_t        wt_done_intr,
  output intr_t        dat_done_intr
);

  logic     add_updt;
  entries_t add_entries;
  slices_t  add_slices;
  entries_t capacity;
  logic     clear;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  cdma_status_ctrl u_ctrl (
    .nvdla_core_clk     (nvdla_core_clk),
    .rst_n              (rst_n),
    .op_en              (op_en),
    .consumer           (consumer),
    .data_bank          (data_bank),
    .dc_state           (dc_state),
    .img_state          (img_state),
    .wt_state           (wt_state),
    .dc_dat_updt        (dc_dat_updt),
    .img_dat_updt       (img_dat_updt),
    .dc_dat_entries     (dc_dat_entries),
    .img_dat_entries    (img_dat_entries),
    .dc_dat_slices      (dc_dat_slices),
    .img_dat_slices     (img_dat_slices),
    .sc_dat_pending_req (sc_dat_pending_req),
    .add_updt           (add_updt),
    .add_entries        (add_entries),
    .add_slices         (add_slices),
    .capacity           (capacity),
    .clear              (clear),
    .pending_ack        (pending_ack),
    .fsm_switch         (fsm_switch),
    .wt_done_intr       (wt_done_intr),
    .dat_done_intr      (dat_done_intr)
  );

  // register view of layer done is the fsm switch pulse
  assign dp_done = fsm_switch;

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  cdma_buf_occupancy u_occupancy (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .add_updt       (add_updt),
    .add_entries    (add_entries),
    .add_slices     (add_slices),
    .sc_dat_updt    (sc_dat_updt),
    .sc_dat_entries (sc_dat_entries),
    .sc_dat_slices  (sc_dat_slices),
    .clear          (clear),
    .capacity       (capacity),
    .valid_slices   (valid_slices),
    .free_entries   (free_entries)
  );

  cdma_wr_idx u_wr_idx (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .add_updt       (add_updt),
    .add_entries    (add_entries),
    .clear          (clear),
    .capacity       (capacity),
    .wr_idx         (wr_idx)
  );

  cdma_updt_delay #(
    .LATENCY (`CDMA_STATUS_LATENCY)
  ) u_updt_delay (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .in_updt        (add_updt),
    .in_entries     (add_entries),
    .in_slices      (add_slices),
    .out_updt       (sc_fwd_updt),
    .out_entries    (sc_fwd_entries),
    .out_slices     (sc_fwd_slices)
  );

endmodule

`default_nettype wire

// ==== cdma_status_tb.sv ====
// table-driven check of the buffer status top against a cycle model; stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

`include "cdma_status_defines.svh"

module cdma_status_tb
  import cdma_status_pkg::*;
();

  localparam int LAT = `CDMA_STATUS_LATENCY;

  // one row of stimulus where sel picks none (0), dc (1) or img (2)
  typedef struct packed {
    logic [1:0]   sel;
    entries_t     ent;
    slices_t      sli;
    logic         rel;
    entries_t     rel_ent;
    slices_t      rel_sli;
    logic         req;
    logic         op_en;
    bank_t        bank;
    logic         cons;
    fetch_state_e dc_st;
    fetch_state_e img_st;
    fetch_state_e wt_st;
  } step_t;

  logic         nvdla_core_clk;
  logic         rst_n;
  logic         dc_dat_updt;
  entries_t     dc_dat_entries;
  slices_t      dc_dat_slices;
  fetch_state_e dc_state;
  logic         img_dat_updt;
  entries_t     img_dat_entries;
  slices_t      img_dat_slices;
  fetch_state_e img_state;
  fetch_state_e wt_state;
  logic         sc_dat_updt;
  entries_t     sc_dat_entries;
  slices_t      sc_dat_slices;
  logic         sc_dat_pending_req;
  logic         op_en;
  bank_t        data_bank;
  logic         consumer;
  logic         sc_fwd_updt;
  entries_t     sc_fwd_entries;
  slices_t      sc_fwd_slices;
  slices_t      valid_slices;
  entries_t     free_entries;
  entries_t     wr_idx;
  logic         pending_ack;
  logic         fsm_switch;
  logic         dp_done;
  intr_t        wt_done_intr;
  intr_t        dat_done_intr;

  // register file and state settings that new rows pick up
  logic         cfg_op_en;
  bank_t        cfg_bank;
  logic         cfg_cons;
  logic         cfg_req;
  fetch_state_e cfg_dc;
  fetch_state_e cfg_img;
  fetch_state_e cfg_wt;

  step_t        steps[$];
  int           cyc;

  // reference model state
  entries_t     m_valid_ent;
  slices_t      m_valid_sli;
  entries_t     m_free;
  entries_t     m_wr;
  entries_t     m_cap;
  logic         m_ack;
  logic         m_req;
  logic         m_wt_seen;
  logic         m_dat_seen;
  logic         m_fsm;
  intr_t        m_wt_intr;
  intr_t        m_dat_intr;
  // forwards still in flight with their due cycle and payload
  int           due_q[$];
  entries_t     fwd_ent_q[$];
  slices_t      fwd_sli_q[$];

  cdma_status i_dut (.*);

  always #10 nvdla_core_clk = ~nvdla_core_clk;

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
    $display("FAILED time=%0t %s actual=0x%0h expected=0x%0h", $time, name, actual, expected);
    $display("TEST FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic check_entries(input string name, input entries_t actual, input entries_t expected);
    if (actual !== expected) begin
      report_mismatch(name, 32'(actual), 32'(expected));
    end
  endtask

  task automatic check_slices(input string name, input slices_t actual, input slices_t expected);
    if (actual !== expected) begin
      report_mismatch(name, 32'(actual), 32'(expected));
    end
  endtask

  task automatic check_intr(input string name, input intr_t actual, input intr_t expected);
    if (actual !== expected) begin
      report_mismatch(name, 32'(actual), 32'(expected));
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      report_mismatch(name, 32'(actual), 32'(expected));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  function automatic step_t make_step(input logic [1:0] sel, input entries_t ent,
                                      input slices_t sli, input entries_t rel_ent,
                                      input slices_t rel_sli);
    step_t s;
    s.sel     = sel;
    s.ent     = ent;
    s.sli     = sli;
    s.rel     = (rel_ent != '0) || (rel_sli != '0);
    s.rel_ent = rel_ent;
    s.rel_sli = rel_sli;
    s.req     = cfg_req;
    s.op_en   = cfg_op_en;
    s.bank    = cfg_bank;
    s.cons    = cfg_cons;
    s.dc_st   = cfg_dc;
    s.img_st  = cfg_img;
    s.wt_st   = cfg_wt;
    return s;
  endfunction

  task automatic add_step(input logic [1:0] sel, input entries_t ent, input slices_t sli,
                          input entries_t rel_ent, input slices_t rel_sli);
    steps.push_back(make_step(sel, ent, sli, rel_ent, rel_sli));
  endtask

  task automatic build_table();
    integer   seed;
    entries_t ent;
    slices_t  sli;
    seed      = 32'h9b93;
    cfg_op_en = 1'b1;
    // let the bank capacity latch before any write
    repeat (3) add_step(0, 0, 0, 0, 0);
    // writes raise the counts and a release brings them down
    add_step(1, 100, 7, 0, 0);
    add_step(2, 50, 3, 0, 0);
    add_step(0, 0, 0, 0, 0);
    add_step(0, 0, 0, 60, 4);
    // back to back adds keep several forwards in flight
    add_step(1, 20, 1, 0, 0);
    add_step(2, 30, 2, 0, 0);
    add_step(1, 40, 3, 0, 0);
    // matched releases hold occupancy while the index wraps at 512
    add_step(1, 200, 5, 200, 5);
    add_step(2, 150, 2, 150, 2);
    for (int i = 0; i < 12; i++) begin
      ent = entries_t'(($random(seed) & 32'hff) + 1);
      sli = slices_t'($random(seed) & 32'hf);
      add_step((i % 2 == 0) ? 2'd1 : 2'd2, ent, sli, ent, sli);
    end
    // two banks move the wrap point to 1024
    cfg_bank = 5'd1;
    add_step(0, 0, 0, 0, 0);
    for (int i = 0; i < 8; i++) begin
      ent = entries_t'(($random(seed) & 32'h1ff) + 1);
      sli = slices_t'($random(seed) & 32'hf);
      add_step((i % 2 == 0) ? 2'd2 : 2'd1, ent, sli, ent, sli);
    end
    // dc parked in pend while the sc asks for a flush
    cfg_dc  = FETCH_PEND;
    cfg_req = 1'b1;
    repeat (3) add_step(0, 0, 0, 0, 0);
    cfg_dc  = FETCH_IDLE;
    cfg_req = 1'b0;
    repeat (2) add_step(0, 0, 0, 0, 0);
    add_step(1, 64, 4, 0, 0);
    // weight done first on consumer 1
    cfg_cons = 1'b1;
    cfg_wt   = FETCH_DONE;
    repeat (2) add_step(0, 0, 0, 0, 0);
    // data done on consumer 1 completes the layer
    cfg_dc = FETCH_DONE;
    repeat (2) add_step(0, 0, 0, 0, 0);
    cfg_wt = FETCH_IDLE;
    cfg_dc = FETCH_IDLE;
    repeat (2) add_step(0, 0, 0, 0, 0);
    // both done together on the img side for consumer 0
    cfg_cons = 1'b0;
    cfg_wt   = FETCH_DONE;
    cfg_img  = FETCH_DONE;
    repeat (2) add_step(0, 0, 0, 0, 0);
    cfg_wt  = FETCH_IDLE;
    cfg_img = FETCH_IDLE;
    repeat (2) add_step(0, 0, 0, 0, 0);
  endtask

  //////////////////////////////////////////////////
  // drive, model and check
  //////////////////////////////////////////////////

  task automatic drive_step(input step_t s);
    dc_dat_updt        = (s.sel == 2'd1);
    // the idle producer carries an inverted payload so a wrong merge shows up
    dc_dat_entries     = (s.sel == 2'd1) ? s.ent : ~s.ent;
    dc_dat_slices      = (s.sel == 2'd1) ? s.sli : ~s.sli;
    img_dat_updt       = (s.sel == 2'd2);
    img_dat_entries    = (s.sel == 2'd2) ? s.ent : ~s.ent;
    img_dat_slices     = (s.sel == 2'd2) ? s.sli : ~s.sli;
    sc_dat_updt        = s.rel;
    sc_dat_entries     = s.rel_ent;
    sc_dat_slices      = s.rel_sli;
    sc_dat_pending_req = s.req;
    op_en              = s.op_en;
    data_bank          = s.bank;
    consumer           = s.cons;
    dc_state           = s.dc_st;
    img_state          = s.img_st;
    wt_state           = s.wt_st;
  endtask

  // next register values from the current model state and this row
  task automatic update_model(input step_t s);
    int   sum;
    int   nxt_ent;
    int   nxt_sli;
    logic add;
    logic wt_d;
    logic dat_d;
    add     = (s.sel != 2'd0);
    nxt_ent = int'(m_valid_ent) + (add ? int'(s.ent) : 0) - (s.rel ? int'(s.rel_ent) : 0);
    nxt_sli = int'(m_valid_sli) + (add ? int'(s.sli) : 0) - (s.rel ? int'(s.rel_sli) : 0);
    // flush wins over both add and release
    if (m_ack && m_req) begin
      nxt_ent = 0;
      nxt_sli = 0;
      m_wr    = '0;
    end else if (add) begin
      sum = int'(m_wr) + int'(s.ent);
      if (sum >= int'(m_cap)) begin
        sum = sum - int'(m_cap);
      end
      m_wr = entries_t'(sum);
    end
    m_free      = entries_t'(int'(m_cap) - nxt_ent);
    m_valid_ent = entries_t'(nxt_ent);
    m_valid_sli = slices_t'(nxt_sli);
    if (add) begin
      due_q.push_back(cyc + LAT);
      fwd_ent_q.push_back(s.ent);
      fwd_sli_q.push_back(s.sli);
    end
    wt_d  = (s.wt_st == FETCH_DONE);
    dat_d = (s.dc_st == FETCH_DONE) || (s.img_st == FETCH_DONE);
    // done rising edge goes to the bit of the selected consumer
    m_wt_intr  = (s.op_en && wt_d && !m_wt_seen) ? (s.cons ? 2'b10 : 2'b01) : 2'b00;
    m_dat_intr = (s.op_en && dat_d && !m_dat_seen) ? (s.cons ? 2'b10 : 2'b01) : 2'b00;
    m_fsm      = s.op_en && wt_d && dat_d && !m_fsm;
    m_wt_seen  = s.op_en && wt_d;
    m_dat_seen = s.op_en && dat_d;
    m_ack      = s.op_en && ((s.dc_st == FETCH_PEND) || (s.img_st == FETCH_PEND));
    m_req      = s.req;
    if (s.op_en) begin
      m_cap = entries_t'((int'(s.bank) + 1) << `CDMA_BANK_DEPTH_LOG2);
    end
  endtask

  task automatic check_outputs();
    check_slices("valid_slices", valid_slices, m_valid_sli);
    check_entries("free_entries", free_entries, m_free);
    check_entries("wr_idx", wr_idx, m_wr);
    check_bit("pending_ack", pending_ack, m_ack);
    check_bit("fsm_switch", fsm_switch, m_fsm);
    check_bit("dp_done", dp_done, m_fsm);
    check_intr("wt_done_intr", wt_done_intr, m_wt_intr);
    check_intr("dat_done_intr", dat_done_intr, m_dat_intr);
    // payload only counts while the forward strobe is high
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      check_bit("sc_fwd_updt", sc_fwd_updt, 1'b1);
      check_entries("sc_fwd_entries", sc_fwd_entries, fwd_ent_q[0]);
      check_slices("sc_fwd_slices", sc_fwd_slices, fwd_sli_q[0]);
      void'(due_q.pop_front());
      void'(fwd_ent_q.pop_front());
      void'(fwd_sli_q.pop_front());
    end else begin
      check_bit("sc_fwd_updt", sc_fwd_updt, 1'b0);
    end
  endtask

  // sample 1 ns after the edge and drive 2 ns after it
  task automatic run_cycle(input step_t s);
    @(posedge nvdla_core_clk);
    #1;
    check_outputs();
    #1;
    drive_step(s);
    update_model(s);
    cyc++;
  endtask

  // idle cycles until every forward has come out
  task automatic drain_forwards();
    int waited;
    waited = 0;
    while (due_q.size() > 0 || waited < 2) begin
      if (waited > 2 * LAT + 4) begin
        $display("timeout: forwards to the sc never arrived");
        $display("TEST FAILED");
        $fatal(1, "forward drain timeout");
      end
      run_cycle(make_step(0, 0, 0, 0, 0));
      waited++;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    nvdla_core_clk = 1'b0;
    rst_n          = 1'b0;
    cyc            = 0;
    cfg_op_en      = 1'b0;
    cfg_bank       = '0;
    cfg_cons       = 1'b0;
    cfg_req        = 1'b0;
    cfg_dc         = FETCH_IDLE;
    cfg_img        = FETCH_IDLE;
    cfg_wt         = FETCH_IDLE;
    m_valid_ent    = '0;
    m_valid_sli    = '0;
    m_free         = '0;
    m_wr           = '0;
    m_cap          = '0;
    m_ack          = 1'b0;
    m_req          = 1'b0;
    m_wt_seen      = 1'b0;
    m_dat_seen     = 1'b0;
    m_fsm          = 1'b0;
    m_wt_intr      = '0;
    m_dat_intr     = '0;
    drive_step(make_step(0, 0, 0, 0, 0));
    build_table();
    repeat (3) @(posedge nvdla_core_clk);
    #2;
    rst_n = 1'b1;
    foreach (steps[i]) begin
      run_cycle(steps[i]);
    end
    drain_forwards();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
cdma_status_pkg.sv
cdma_updt_delay.sv
cdma_wr_idx.sv
cdma_buf_occupancy.sv
cdma_status_ctrl.sv
cdma_status.sv
cdma_status_tb.sv
